// ==== kernel_weight_loader.f ====
kw_geom_pkg.sv
kw_bus_pkg.sv
kw_axil_slave.sv
kw_weight_mem.sv
kw_fetch_sequencer.sv
kw_stream_fifo.sv
kernel_weight_loader.sv
tb_kernel_weight_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_kernel_weight_loader \
    -f kernel_weight_loader.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

// ==== tb_kernel_weight_loader.sv ====
`timescale 1ns/10ps

module tb_kernel_weight_loader
    import kw_geom_pkg::*;
    import kw_bus_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int HS_LIMIT   = 64;
    localparam int JOB_LIMIT  = 2000;
    // Cycle budget of each test
    localparam int BUDGET_REGS     = 1000;
    localparam int BUDGET_WEIGHTS  = 2000;
    localparam int BUDGET_STREAM   = 4000;
    localparam int BUDGET_STALL    = 4000;
    localparam int BUDGET_HOST     = 4000;
    localparam int BUDGET_RESTART  = 5000;
    localparam int WATCHDOG_CYCLES = BUDGET_REGS + BUDGET_WEIGHTS + BUDGET_STREAM
                                   + BUDGET_STALL + BUDGET_HOST + BUDGET_RESTART;

    logic                   i_clock;
    logic                   i_reset;
    logic [AXI_ADDR_W-1:0]  i_axi_awaddr;
    logic                   i_axi_awvalid;
    logic                   o_axi_awready;
    logic [AXI_DATA_W-1:0]  i_axi_wdata;
    logic                   i_axi_wvalid;
    logic                   o_axi_wready;
    logic [RESP_W-1:0]      o_axi_bresp;
    logic                   o_axi_bvalid;
    logic                   i_axi_bready;
    logic [AXI_ADDR_W-1:0]  i_axi_araddr;
    logic                   i_axi_arvalid;
    logic                   o_axi_arready;
    logic [AXI_DATA_W-1:0]  o_axi_rdata;
    logic [RESP_W-1:0]      o_axi_rresp;
    logic                   o_axi_rvalid;
    logic                   i_axi_rready;
    logic                   o_weight_valid;
    logic [WORD_W-1:0]      o_weight_data;
    logic                   o_weight_group_end;
    logic                   o_weight_last;
    logic                   i_weight_ready;

    integer                 seed = 32'h8e066d69;
    logic [31:0]            ready_rnd;
    // 0 ready high, 1 random, 2 held low
    int                     ready_mode;
    logic                   collecting;
    logic                   last_seen;
    logic [WEIGHT_W-1:0]    model [MEM_DEPTH][LANES];
    logic [WORD_W-1:0]      exp_data [$];
    logic                   exp_gend [$];
    logic                   exp_last [$];
    logic [WORD_W-1:0]      got_data [$];
    logic                   got_gend [$];
    logic                   got_last [$];

    kernel_weight_loader i_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    task automatic fail_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        fail_run("watchdog expired before the tests finished");
    end

    always @(posedge i_clock) begin
        if (ready_mode == 1) begin
            ready_rnd = $random(seed);
            i_weight_ready <= ready_rnd[0];
        end else begin
            i_weight_ready <= (ready_mode == 0);
        end
    end

    // Stream monitor
    always @(posedge i_clock) begin
        if (i_reset && o_weight_valid && i_weight_ready) begin
            if (!collecting) begin
                fail_run("a stream word arrived while no job was expected");
            end
            got_data.push_back(o_weight_data);
            got_gend.push_back(o_weight_group_end);
            got_last.push_back(o_weight_last);
            if (o_weight_last) begin
                last_seen = 1'b1;
            end
        end
    end

    function automatic int layout_addr(input int g, input int chans, input int c, input int e);
        return (g * chans + c) * ELEMENTS + e;
    endfunction

    function automatic int weight_addr(input int word, input int lane);
        return int'(WEIGHT_BASE) + word * 16 + lane * 4;
    endfunction

    task automatic axil_write(input int addr, input logic [31:0] data,
                              input logic [RESP_W-1:0] exp_resp);
        int n;
        @(posedge i_clock);
        i_axi_awaddr  <= AXI_ADDR_W'(addr);
        i_axi_awvalid <= 1'b1;
        i_axi_wdata   <= data;
        i_axi_wvalid  <= 1'b1;
        i_axi_bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge i_clock);
            n++;
        end while (!o_axi_awready && n < HS_LIMIT);
        if (!o_axi_awready) begin
            fail_run("the write address and data handshake never completed");
        end
        check_value(o_axi_wready, 1, "WREADY together with AWREADY");
        i_axi_awvalid <= 1'b0;
        i_axi_wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge i_clock);
            n++;
        end while (!o_axi_bvalid && n < HS_LIMIT);
        if (!o_axi_bvalid) begin
            fail_run("the write response never arrived");
        end
        check_value(n, 1, "cycles from write accept to BVALID");
        check_value(o_axi_bresp, exp_resp, $sformatf("write response at %0h", addr));
        i_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input int addr, input logic [RESP_W-1:0] exp_resp,
                             output logic [31:0] data);
        int n;
        @(posedge i_clock);
        i_axi_araddr  <= AXI_ADDR_W'(addr);
        i_axi_arvalid <= 1'b1;
        i_axi_rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge i_clock);
            n++;
        end while (!o_axi_arready && n < HS_LIMIT);
        if (!o_axi_arready) begin
            fail_run("the read address handshake never completed");
        end
        i_axi_arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge i_clock);
            n++;
        end while (!o_axi_rvalid && n < HS_LIMIT);
        if (!o_axi_rvalid) begin
            fail_run("the read data never arrived");
        end
        check_value(n, 2, "cycles from read accept to RVALID");
        check_value(o_axi_rresp, exp_resp, $sformatf("read response at %0h", addr));
        data = o_axi_rdata;
        i_axi_rready <= 1'b0;
    endtask

    task automatic write_weight(input int word, input int lane, input logic [31:0] value);
        axil_write(weight_addr(word, lane), value, RESP_OKAY);
        model[word][lane] = value;
    endtask

    task automatic check_weight(input int word, input int lane);
        logic [31:0] value;
        axil_read(weight_addr(word, lane), RESP_OKAY, value);
        check_value(value, model[word][lane], $sformatf("weight word %0d lane %0d", word, lane));
    endtask

    task automatic check_reg(input int addr, input logic [31:0] expected, input string what);
        logic [31:0] value;
        axil_read(addr, RESP_OKAY, value);
        check_value(value, expected, what);
    endtask

    task automatic start_job(input int chans, input int first_group, input int last_group);
        logic [WORD_W-1:0] word;
        int addr;
        exp_data.delete();
        exp_gend.delete();
        exp_last.delete();
        got_data.delete();
        got_gend.delete();
        got_last.delete();
        for (int g = first_group; g <= last_group; g++) begin
            for (int c = 0; c < chans; c++) begin
                for (int e = 0; e < ELEMENTS; e++) begin
                    addr = layout_addr(g, chans, c, e);
                    for (int k = 0; k < LANES; k++) begin
                        word[k * WEIGHT_W +: WEIGHT_W] = model[addr][k];
                    end
                    exp_data.push_back(word);
                    exp_gend.push_back(c == chans - 1 && e == ELEMENTS - 1);
                    exp_last.push_back(c == chans - 1 && e == ELEMENTS - 1 && g == last_group);
                end
            end
        end
        last_seen  = 1'b0;
        collecting = 1'b1;
        axil_write(REG_CHANNELS, chans, RESP_OKAY);
        axil_write(REG_START_GROUP, first_group, RESP_OKAY);
        axil_write(REG_END_GROUP, last_group, RESP_OKAY);
        axil_write(REG_CONTROL, 1, RESP_OKAY);
    endtask

    task automatic finish_job();
        int n;
        n = 0;
        while (!last_seen && n < JOB_LIMIT) begin
            @(posedge i_clock);
            n++;
        end
        if (!last_seen) begin
            fail_run("the job never delivered its last word");
        end
        @(posedge i_clock);
        check_value(o_weight_valid, 0, "stream valid after the last word");
        collecting = 1'b0;
        check_value(got_data.size(), exp_data.size(), "stream word count");
        for (int i = 0; i < exp_data.size(); i++) begin
            check_value(got_data[i], exp_data[i], $sformatf("stream word %0d data", i + 1));
            check_value(got_gend[i], exp_gend[i], $sformatf("stream word %0d group_end", i + 1));
            check_value(got_last[i], exp_last[i], $sformatf("stream word %0d last", i + 1));
        end
    endtask

    task automatic registers_and_errors();
        logic [31:0] value;
        check_value(o_weight_valid, 0, "stream valid after reset");
        check_value(o_axi_bvalid, 0, "BVALID after reset");
        check_value(o_axi_rvalid, 0, "RVALID after reset");
        check_reg(REG_CONTROL, 0, "control after reset");
        axil_write(REG_CHANNELS, 5, RESP_OKAY);
        axil_write(REG_START_GROUP, 3, RESP_OKAY);
        axil_write(REG_END_GROUP, 7, RESP_OKAY);
        check_reg(REG_CHANNELS, 5, "channels register");
        check_reg(REG_START_GROUP, 3, "start group register");
        check_reg(REG_END_GROUP, 7, "end group register");
        axil_write(16'hA000, 32'h1234, RESP_SLVERR);
        axil_read(16'hA000, RESP_SLVERR, value);
        axil_read(16'h0006, RESP_SLVERR, value);
    endtask

    task automatic weight_readback();
        int lane;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < LANES; k++) begin
                write_weight(300 + i * 5, k, $random(seed));
            end
        end
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < LANES; k++) begin
                check_weight(300 + i * 5, k);
            end
        end
        // Rewriting one lane keeps the other lanes
        lane = $unsigned($random(seed)) % LANES;
        write_weight(310, lane, $random(seed));
        for (int k = 0; k < LANES; k++) begin
            check_weight(310, k);
        end
    endtask

    task automatic stream_in_order();
        // Fill every word of groups 1 and 2 for a 2 channel job
        for (int w = layout_addr(1, 2, 0, 0); w <= layout_addr(2, 2, 1, 8); w++) begin
            for (int k = 0; k < LANES; k++) begin
                write_weight(w, k, $random(seed));
            end
        end
        start_job(2, 1, 2);
        finish_job();
        check_reg(REG_CONTROL, 2, "control done after job");
    endtask

    task automatic stream_under_stall();
        ready_mode = 1;
        start_job(2, 1, 2);
        finish_job();
        ready_mode = 0;
    endtask

    task automatic host_reads_mid_job();
        int word;
        ready_mode = 1;
        start_job(2, 1, 2);
        for (int i = 0; i < 4; i++) begin
            word = layout_addr(1, 2, 0, 0) + $unsigned($random(seed)) % 36;
            check_weight(word, $unsigned($random(seed)) % LANES);
        end
        check_reg(REG_CONTROL, 1, "control busy after host reads");
        finish_job();
        ready_mode = 0;
    endtask

    task automatic restart_while_busy();
        ready_mode = 2;
        start_job(2, 1, 2);
        check_reg(REG_CONTROL, 1, "control busy during job");
        axil_write(REG_CONTROL, 1, RESP_OKAY);
        check_reg(REG_CONTROL, 1, "control after a start while busy");
        ready_mode = 0;
        finish_job();
        check_reg(REG_CONTROL, 2, "control after restarted job");
    endtask

    initial begin
        i_reset       = 1'b0;
        i_axi_awaddr  = '0;
        i_axi_awvalid = 1'b0;
        i_axi_wdata   = '0;
        i_axi_wvalid  = 1'b0;
        i_axi_bready  = 1'b0;
        i_axi_araddr  = '0;
        i_axi_arvalid = 1'b0;
        i_axi_rready  = 1'b0;
        i_weight_ready = 1'b0;
        ready_mode    = 0;
        collecting    = 1'b0;
        last_seen     = 1'b0;
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b1;
        registers_and_errors();
        weight_readback();
        stream_in_order();
        stream_under_stall();
        host_reads_mid_job();
        restart_while_busy();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== kernel_weight_loader.sv ====
`timescale 1ns/10ps

module kernel_weight_loader
    import kw_geom_pkg::*;
    import kw_bus_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic [AXI_ADDR_W-1:0]   i_axi_awaddr,
    input  logic                    i_axi_awvalid,
    output logic                    o_axi_awready,
    input  logic [AXI_DATA_W-1:0]   i_axi_wdata,
    input  logic                    i_axi_wvalid,
    output logic                    o_axi_wready,
    output logic [RESP_W-1:0]       o_axi_bresp,
    output logic                    o_axi_bvalid,
    input  logic                    i_axi_bready,
    input  logic [AXI_ADDR_W-1:0]   i_axi_araddr,
    input  logic                    i_axi_arvalid,
    output logic                    o_axi_arready,
    output logic [AXI_DATA_W-1:0]   o_axi_rdata,
    output logic [RESP_W-1:0]       o_axi_rresp,
    output logic                    o_axi_rvalid,
    input  logic                    i_axi_rready,
    output logic                    o_weight_valid,
    output logic [WORD_W-1:0]       o_weight_data,
    output logic                    o_weight_group_end,
    output logic                    o_weight_last,
    input  logic                    i_weight_ready
);

    logic                   host_req;
    logic                   host_we;
    logic [LANE_W-1:0]      host_lane;
    logic [MEM_ADDR_W-1:0]  host_addr;
    logic [WEIGHT_W-1:0]    host_wdata;
    logic [WORD_W-1:0]      host_rdata;
    logic                   fetch_req;
    logic [MEM_ADDR_W-1:0]  fetch_addr;
    logic                   fetch_gnt;
    logic                   fetch_rvalid;
    logic [WORD_W-1:0]      fetch_rdata;
    logic                   start;
    logic [CHAN_W-1:0]      channels;
    logic [GROUP_W-1:0]     start_group;
    logic [GROUP_W-1:0]     end_group;
    logic                   busy;
    logic                   done;
    logic                   push;
    logic [WORD_W-1:0]      push_data;
    logic                   push_group_end;
    logic                   push_last;
    logic [FIFO_CNT_W-1:0]  fifo_count;
    logic                   fifo_pop_last;

    kw_axil_slave u_slave (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_axi_awaddr   (i_axi_awaddr),
        .i_axi_awvalid  (i_axi_awvalid),
        .o_axi_awready  (o_axi_awready),
        .i_axi_wdata    (i_axi_wdata),
        .i_axi_wvalid   (i_axi_wvalid),
        .o_axi_wready   (o_axi_wready),
        .o_axi_bresp    (o_axi_bresp),
        .o_axi_bvalid   (o_axi_bvalid),
        .i_axi_bready   (i_axi_bready),
        .i_axi_araddr   (i_axi_araddr),
        .i_axi_arvalid  (i_axi_arvalid),
        .o_axi_arready  (o_axi_arready),
        .o_axi_rdata    (o_axi_rdata),
        .o_axi_rresp    (o_axi_rresp),
        .o_axi_rvalid   (o_axi_rvalid),
        .i_axi_rready   (i_axi_rready),
        .o_host_req     (host_req),
        .o_host_we      (host_we),
        .o_host_lane    (host_lane),
        .o_host_addr    (host_addr),
        .o_host_wdata   (host_wdata),
        .i_host_rdata   (host_rdata),
        .o_start        (start),
        .o_channels     (channels),
        .o_start_group  (start_group),
        .o_end_group    (end_group),
        .i_busy         (busy),
        .i_done         (done)
    );

    kw_weight_mem u_mem (
        .i_clock        (i_clock),
        .i_host_req     (host_req),
        .i_host_we      (host_we),
        .i_host_lane    (host_lane),
        .i_host_addr    (host_addr),
        .i_host_wdata   (host_wdata),
        .o_host_rdata   (host_rdata),
        .i_fetch_req    (fetch_req),
        .i_fetch_addr   (fetch_addr),
        .o_fetch_gnt    (fetch_gnt),
        .o_fetch_rvalid (fetch_rvalid),
        .o_fetch_rdata  (fetch_rdata)
    );

    kw_fetch_sequencer u_sequencer (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_start          (start),
        .i_channels       (channels),
        .i_start_group    (start_group),
        .i_end_group      (end_group),
        .o_busy           (busy),
        .o_done           (done),
        .o_fetch_req      (fetch_req),
        .o_fetch_addr     (fetch_addr),
        .i_fetch_gnt      (fetch_gnt),
        .i_fetch_rvalid   (fetch_rvalid),
        .i_fetch_rdata    (fetch_rdata),
        .o_push           (push),
        .o_push_data      (push_data),
        .o_push_group_end (push_group_end),
        .o_push_last      (push_last),
        .i_fifo_count     (fifo_count),
        .i_fifo_pop_last  (fifo_pop_last)
    );

    kw_stream_fifo u_fifo (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (push),
        .i_data      (push_data),
        .i_group_end (push_group_end),
        .i_last      (push_last),
        .o_count     (fifo_count),
        .o_valid     (o_weight_valid),
        .o_data      (o_weight_data),
        .o_group_end (o_weight_group_end),
        .o_last      (o_weight_last),
        .i_ready     (i_weight_ready),
        .o_pop_last  (fifo_pop_last)
    );

endmodule

// ==== kw_stream_fifo.sv ====
`timescale 1ns/10ps

module kw_stream_fifo
    import kw_geom_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_push,
    input  logic [WORD_W-1:0]       i_data,
    input  logic                    i_group_end,
    input  logic                    i_last,
    output logic [FIFO_CNT_W-1:0]   o_count,
    output logic                    o_valid,
    output logic [WORD_W-1:0]       o_data,
    output logic                    o_group_end,
    output logic                    o_last,
    input  logic                    i_ready,
    output logic                    o_pop_last
);

    // Data word with the two tag bits on top
    logic [WORD_W+1:0]      buffer [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic                   pop;

    assign o_valid    = (o_count != '0);
    assign pop        = o_valid && i_ready;
    assign {o_last, o_group_end, o_data} = buffer[rd_ptr];
    assign o_pop_last = pop && o_last;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_count <= o_count + FIFO_CNT_W'(i_push) - FIFO_CNT_W'(pop);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_push) begin
            buffer[wr_ptr] <= {i_last, i_group_end, i_data};
        end
    end

endmodule

// ==== kw_fetch_sequencer.sv ====
`timescale 1ns/10ps

module kw_fetch_sequencer
    import kw_geom_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_start,
    input  logic [CHAN_W-1:0]       i_channels,
    input  logic [GROUP_W-1:0]      i_start_group,
    input  logic [GROUP_W-1:0]      i_end_group,
    output logic                    o_busy,
    output logic                    o_done,
    output logic                    o_fetch_req,
    output logic [MEM_ADDR_W-1:0]   o_fetch_addr,
    input  logic                    i_fetch_gnt,
    input  logic                    i_fetch_rvalid,
    input  logic [WORD_W-1:0]       i_fetch_rdata,
    output logic                    o_push,
    output logic [WORD_W-1:0]       o_push_data,
    output logic                    o_push_group_end,
    output logic                    o_push_last,
    input  logic [FIFO_CNT_W-1:0]   i_fifo_count,
    input  logic                    i_fifo_pop_last
);

    typedef enum logic [1:0] {S_IDLE, S_SETUP, S_RUN, S_DRAIN} state_t;

    state_t                 state;
    logic [CHAN_W-1:0]      channels_q;
    logic [GROUP_W-1:0]     end_group_q;
    logic [GROUP_W-1:0]     group;
    logic [CHAN_W-1:0]      chan;
    logic [ELEM_W-1:0]      elem;
    logic [1:0]             inflight;
    logic [FIFO_CNT_W:0]    credit_used;
    logic                   group_end;
    logic                   job_last;
    logic                   tag_group_end;
    logic                   tag_last;

    assign group_end   = (elem == ELEM_W'(ELEMENTS - 1)) && (chan == channels_q - 1'b1);
    assign job_last    = group_end && (group == end_group_q);

    // Words in the FIFO plus reads not yet returned
    assign credit_used = (FIFO_CNT_W + 1)'(i_fifo_count) + (FIFO_CNT_W + 1)'(inflight);
    assign o_fetch_req = (state == S_RUN) && (credit_used < FIFO_DEPTH);
    assign o_busy      = (state != S_IDLE);

    assign o_push           = i_fetch_rvalid;
    assign o_push_data      = i_fetch_rdata;
    assign o_push_group_end = tag_group_end;
    assign o_push_last      = tag_last;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state    <= S_IDLE;
            o_done   <= 1'b0;
            inflight <= '0;
        end else begin
            inflight <= inflight + 2'(i_fetch_gnt) - 2'(i_fetch_rvalid);
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state  <= S_SETUP;
                        o_done <= 1'b0;
                    end
                end
                S_SETUP: state <= S_RUN;
                S_RUN: begin
                    if (i_fetch_gnt && job_last) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (i_fifo_pop_last) begin
                        state  <= S_IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == S_IDLE && i_start) begin
            channels_q  <= i_channels;
            end_group_q <= i_end_group;
            group       <= i_start_group;
        end
        // First word of the start group, computed once
        if (state == S_SETUP) begin
            o_fetch_addr <= MEM_ADDR_W'(group * channels_q * ELEMENTS);
            chan         <= '0;
            elem         <= '0;
        end
        if (i_fetch_gnt) begin
            // Tags ride alongside the one-cycle read
            tag_group_end <= group_end;
            tag_last      <= job_last;
            o_fetch_addr  <= o_fetch_addr + 1'b1;
            if (elem == ELEM_W'(ELEMENTS - 1)) begin
                elem <= '0;
                if (chan == channels_q - 1'b1) begin
                    chan  <= '0;
                    group <= group + 1'b1;
                end else begin
                    chan <= chan + 1'b1;
                end
            end else begin
                elem <= elem + 1'b1;
            end
        end
    end

endmodule

// ==== kw_weight_mem.sv ====
`timescale 1ns/10ps

module kw_weight_mem
    import kw_geom_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_host_req,
    input  logic                    i_host_we,
    input  logic [LANE_W-1:0]       i_host_lane,
    input  logic [MEM_ADDR_W-1:0]   i_host_addr,
    input  logic [WEIGHT_W-1:0]     i_host_wdata,
    output logic [WORD_W-1:0]       o_host_rdata,
    input  logic                    i_fetch_req,
    input  logic [MEM_ADDR_W-1:0]   i_fetch_addr,
    output logic                    o_fetch_gnt,
    output logic                    o_fetch_rvalid,
    output logic [WORD_W-1:0]       o_fetch_rdata
);

    logic [WORD_W-1:0]      mem [MEM_DEPTH];
    logic [WORD_W-1:0]      rd_data;
    logic [MEM_ADDR_W-1:0]  rd_addr;
    logic                   rd_en;

    // Host always wins the single port
    assign o_fetch_gnt = i_fetch_req && !i_host_req;
    assign rd_addr     = i_host_req ? i_host_addr : i_fetch_addr;
    assign rd_en       = (i_host_req && !i_host_we) || o_fetch_gnt;

    always_ff @(posedge i_clock) begin
        if (i_host_req && i_host_we) begin
            for (int k = 0; k < LANES; k++) begin
                if (i_host_lane == LANE_W'(k)) begin
                    mem[i_host_addr][k * WEIGHT_W +: WEIGHT_W] <= i_host_wdata;
                end
            end
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
        o_fetch_rvalid <= o_fetch_gnt;
    end

    // Both ports see the one output register
    assign o_host_rdata  = rd_data;
    assign o_fetch_rdata = rd_data;

endmodule

// ==== kw_axil_slave.sv ====
`timescale 1ns/10ps

module kw_axil_slave
    import kw_geom_pkg::*;
    import kw_bus_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic [AXI_ADDR_W-1:0]   i_axi_awaddr,
    input  logic                    i_axi_awvalid,
    output logic                    o_axi_awready,
    input  logic [AXI_DATA_W-1:0]   i_axi_wdata,
    input  logic                    i_axi_wvalid,
    output logic                    o_axi_wready,
    output logic [RESP_W-1:0]       o_axi_bresp,
    output logic                    o_axi_bvalid,
    input  logic                    i_axi_bready,
    input  logic [AXI_ADDR_W-1:0]   i_axi_araddr,
    input  logic                    i_axi_arvalid,
    output logic                    o_axi_arready,
    output logic [AXI_DATA_W-1:0]   o_axi_rdata,
    output logic [RESP_W-1:0]       o_axi_rresp,
    output logic                    o_axi_rvalid,
    input  logic                    i_axi_rready,
    output logic                    o_host_req,
    output logic                    o_host_we,
    output logic [LANE_W-1:0]       o_host_lane,
    output logic [MEM_ADDR_W-1:0]   o_host_addr,
    output logic [WEIGHT_W-1:0]     o_host_wdata,
    input  logic [WORD_W-1:0]       i_host_rdata,
    output logic                    o_start,
    output logic [CHAN_W-1:0]       o_channels,
    output logic [GROUP_W-1:0]      o_start_group,
    output logic [GROUP_W-1:0]      o_end_group,
    input  logic                    i_busy,
    input  logic                    i_done
);

    logic [1:0]             ar_kind;
    logic [1:0]             aw_kind;
    logic                   ar_hs;
    logic                   wr_hs;
    logic                   rd_pend;
    logic [1:0]             rd_kind;
    logic [LANE_W-1:0]      rd_lane;
    logic [1:0]             rd_reg;
    logic [AXI_DATA_W-1:0]  reg_rdata;

    function automatic logic [1:0] decode(input logic [AXI_ADDR_W-1:0] addr);
        if (addr[1:0] != 2'b00) begin
            return ACC_ERR;
        end
        if (addr >= WEIGHT_BASE && addr <= WEIGHT_LAST) begin
            return ACC_WEIGHT;
        end
        if (addr <= REG_END_GROUP) begin
            return ACC_REG;
        end
        return ACC_ERR;
    endfunction

    assign ar_kind = decode(i_axi_araddr);
    assign aw_kind = decode(i_axi_awaddr);

    // Read has priority, one outstanding per channel
    assign ar_hs = i_axi_arvalid && !rd_pend && !o_axi_rvalid;
    assign wr_hs = i_axi_awvalid && i_axi_wvalid && !o_axi_bvalid && !ar_hs;

    assign o_axi_arready = ar_hs;
    assign o_axi_awready = wr_hs;
    assign o_axi_wready  = wr_hs;

    assign o_host_req   = (ar_hs && ar_kind == ACC_WEIGHT) || (wr_hs && aw_kind == ACC_WEIGHT);
    assign o_host_we    = wr_hs;
    assign o_host_lane  = i_axi_awaddr[2 +: LANE_W];
    assign o_host_addr  = ar_hs ? i_axi_araddr[4 +: MEM_ADDR_W] : i_axi_awaddr[4 +: MEM_ADDR_W];
    assign o_host_wdata = i_axi_wdata;

    always_comb begin
        case (AXI_ADDR_W'({rd_reg, 2'b00}))
            REG_CONTROL:     reg_rdata = AXI_DATA_W'({i_done, i_busy});
            REG_CHANNELS:    reg_rdata = AXI_DATA_W'(o_channels);
            REG_START_GROUP: reg_rdata = AXI_DATA_W'(o_start_group);
            default:         reg_rdata = AXI_DATA_W'(o_end_group);
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rd_pend       <= 1'b0;
            o_axi_rvalid  <= 1'b0;
            o_axi_bvalid  <= 1'b0;
            o_start       <= 1'b0;
            o_channels    <= '0;
            o_start_group <= '0;
            o_end_group   <= '0;
        end else begin
            o_start <= 1'b0;
            rd_pend <= ar_hs;
            if (rd_pend) begin
                o_axi_rvalid <= 1'b1;
            end else if (i_axi_rready) begin
                o_axi_rvalid <= 1'b0;
            end
            if (wr_hs) begin
                o_axi_bvalid <= 1'b1;
            end else if (i_axi_bready) begin
                o_axi_bvalid <= 1'b0;
            end
            if (wr_hs && aw_kind == ACC_REG) begin
                case (i_axi_awaddr)
                    REG_CONTROL:     o_start       <= i_axi_wdata[0];
                    REG_CHANNELS:    o_channels    <= i_axi_wdata[CHAN_W-1:0];
                    REG_START_GROUP: o_start_group <= i_axi_wdata[GROUP_W-1:0];
                    default:         o_end_group   <= i_axi_wdata[GROUP_W-1:0];
                endcase
            end
        end
    end

    // Memory data arrives one cycle after accept, RVALID one cycle later
    always_ff @(posedge i_clock) begin
        if (ar_hs) begin
            rd_kind <= ar_kind;
            rd_lane <= i_axi_araddr[2 +: LANE_W];
            rd_reg  <= i_axi_araddr[3:2];
        end
        if (rd_pend) begin
            case (rd_kind)
                ACC_WEIGHT: begin
                    o_axi_rdata <= i_host_rdata[rd_lane * WEIGHT_W +: WEIGHT_W];
                    o_axi_rresp <= RESP_OKAY;
                end
                ACC_REG: begin
                    o_axi_rdata <= reg_rdata;
                    o_axi_rresp <= RESP_OKAY;
                end
                default: begin
                    o_axi_rdata <= '0;
                    o_axi_rresp <= RESP_SLVERR;
                end
            endcase
        end
        if (wr_hs) begin
            o_axi_bresp <= (aw_kind == ACC_ERR) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// ==== kw_bus_pkg.sv ====
package kw_bus_pkg;

    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 32;
    localparam int RESP_W     = 2;

    // Register map
    localparam logic [AXI_ADDR_W-1:0] REG_CONTROL     = 16'h0000;
    localparam logic [AXI_ADDR_W-1:0] REG_CHANNELS    = 16'h0004;
    localparam logic [AXI_ADDR_W-1:0] REG_START_GROUP = 16'h0008;
    localparam logic [AXI_ADDR_W-1:0] REG_END_GROUP   = 16'h000C;

    // Weight window, byte offset is word * 16 + lane * 4
    localparam logic [AXI_ADDR_W-1:0] WEIGHT_BASE     = 16'h8000;
    localparam logic [AXI_ADDR_W-1:0] WEIGHT_LAST     = 16'h9FFF;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Address decode result
    localparam logic [1:0] ACC_ERR    = 2'd0;
    localparam logic [1:0] ACC_REG    = 2'd1;
    localparam logic [1:0] ACC_WEIGHT = 2'd2;

endpackage

// ==== kw_geom_pkg.sv ====
package kw_geom_pkg;

    // Filters per group, one weight per lane
    localparam int LANES      = 4;
    localparam int LANE_W     = $clog2(LANES);
    localparam int WEIGHT_W   = 32;
    localparam int WORD_W     = LANES * WEIGHT_W;

    // 3x3 kernel
    localparam int ELEMENTS   = 9;
    localparam int ELEM_W     = $clog2(ELEMENTS);

    localparam int MEM_DEPTH  = 512;
    localparam int MEM_ADDR_W = 9;

    localparam int CHAN_W     = 8;
    localparam int GROUP_W    = 8;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = 4;

endpackage
